// File: Makefile
.PHONY: all build run lint clean

all: build run

build:
	verilator --binary -f verilog.f --top-module tb_nox -o Vtb_nox

run:
	@out="$$(./obj_dir/Vtb_nox)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

lint:
	verilator --lint-only -Wall -f verilog.f --top-module nox

clean:
	rm -rf obj_dir

// File: cb_pkg.sv
// Core bus types

package cb_pkg;
  localparam int CB_AW = 32;
  localparam int CB_DW = 32;

  // Master to slave, held until ack
  typedef struct packed {
    logic             req;
    logic             we;
    logic [CB_AW-1:0] addr;
    logic [CB_DW-1:0] wdata;
  } s_cb_mosi_t;

  // Slave to master, ack is a single-cycle pulse
  typedef struct packed {
    logic             ack;
    logic [CB_DW-1:0] rdata;
  } s_cb_miso_t;
endpackage

// File: decode.sv
// Decode stage with register file and scoreboard
`timescale 1ns/1ps

module decode (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                flush_i,
  input  logic                fetch_valid_i,
  output logic                fetch_ready_o,
  input  nox_pkg::instr_raw_t fetch_instr_i,
  input  nox_pkg::pc_t        fetch_pc_i,
  input  nox_pkg::s_wb_t      wb_dec_i,
  output nox_pkg::s_id_ex_t   id_ex_o,
  output nox_pkg::rdata_t     rs1_data_o,
  output nox_pkg::rdata_t     rs2_data_o,
  input  logic                id_ready_i
);
  import nox_pkg::*;

  rdata_t             regfile [NR_REGS];
  logic [NR_REGS-1:0] busy_ff, busy_clr, busy_next;
  s_id_ex_t           dec, id_ex_ff;
  logic               valid_ff, use_rs1, use_rs2, hazard, issue, alu_ok;
  raddr_t             rs1, rs2;
  rdata_t             rs1_val, rs2_val;
  opcode_t            opcode;
  alu_op_t            alu_f3;
  logic [2:0]         funct3;

  always_comb begin
    opcode = opcode_t'(fetch_instr_i[6:0]);
    funct3 = fetch_instr_i[14:12];
    rs1    = fetch_instr_i[19:15];
    rs2    = fetch_instr_i[24:20];
    alu_ok = 1'b1;
    case (funct3)
      3'b000:  alu_f3 = (opcode == OP && fetch_instr_i[30]) ? ALU_SUB : ALU_ADD;
      3'b010:  alu_f3 = ALU_SLT;
      3'b100:  alu_f3 = ALU_XOR;
      3'b110:  alu_f3 = ALU_OR;
      3'b111:  alu_f3 = ALU_AND;
      default: begin
        alu_f3 = ALU_ADD;
        alu_ok = 1'b0;
      end
    endcase
    dec        = '0;
    dec.valid  = 1'b1;
    dec.pc     = fetch_pc_i;
    dec.rd     = fetch_instr_i[11:7];
    dec.alu_op = ALU_ADD;
    use_rs1    = 1'b0;
    use_rs2    = 1'b0;
    case (opcode)
      OP: begin
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
        dec.rd_we  = alu_ok;
        dec.alu_op = alu_f3;
      end
      OP_IMM: begin
        use_rs1     = 1'b1;
        dec.rd_we   = alu_ok;
        dec.alu_op  = alu_f3;
        dec.use_imm = 1'b1;
        dec.imm     = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:20]};
      end
      LUI: begin
        // x0 as first operand gives the bare U immediate
        rs1         = '0;
        dec.rd_we   = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = {fetch_instr_i[31:12], 12'b0};
      end
      LOAD: begin
        use_rs1     = (funct3 == 3'b010);
        dec.rd_we   = (funct3 == 3'b010);
        dec.is_load = (funct3 == 3'b010);
        dec.use_imm = 1'b1;
        dec.imm     = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:20]};
      end
      STORE: begin
        use_rs1      = (funct3 == 3'b010);
        use_rs2      = (funct3 == 3'b010);
        dec.is_store = (funct3 == 3'b010);
        dec.use_imm  = 1'b1;
        dec.imm      = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:25], fetch_instr_i[11:7]};
      end
      BRANCH: begin
        use_rs1       = (funct3[2:1] == 2'b00);
        use_rs2       = (funct3[2:1] == 2'b00);
        dec.is_branch = (funct3[2:1] == 2'b00);
        dec.br_ne     = funct3[0];
        dec.imm       = {{19{fetch_instr_i[31]}}, fetch_instr_i[31], fetch_instr_i[7],
                         fetch_instr_i[30:25], fetch_instr_i[11:8], 1'b0};
      end
      JAL: begin
        dec.rd_we  = 1'b1;
        dec.is_jal = 1'b1;
        dec.imm    = {{11{fetch_instr_i[31]}}, fetch_instr_i[31], fetch_instr_i[19:12],
                      fetch_instr_i[20], fetch_instr_i[30:21], 1'b0};
      end
      default: ;
    endcase
    if (dec.rd == '0) begin
      dec.rd_we = 1'b0;
    end
  end

  always_comb begin
    // A write-back this cycle already frees its register
    busy_clr = '0;
    if (wb_dec_i.we) begin
      busy_clr[wb_dec_i.rd] = 1'b1;
    end
    hazard = (use_rs1 && busy_ff[rs1] && !busy_clr[rs1]) ||
             (use_rs2 && busy_ff[rs2] && !busy_clr[rs2]) ||
             (dec.rd_we && busy_ff[dec.rd] && !busy_clr[dec.rd]);
    fetch_ready_o = !hazard && !flush_i && !(valid_ff && !id_ready_i);
    issue         = fetch_valid_i && fetch_ready_o;
    rs1_val = (rs1 == '0) ? '0 : busy_clr[rs1] ? wb_dec_i.rd_data : regfile[rs1];
    rs2_val = (rs2 == '0) ? '0 : busy_clr[rs2] ? wb_dec_i.rd_data : regfile[rs2];
    busy_next = busy_ff & ~busy_clr;
    // Killed instruction never reaches write-back
    if (flush_i && valid_ff && id_ex_ff.rd_we) begin
      busy_next[id_ex_ff.rd] = 1'b0;
    end
    if (issue && dec.rd_we) begin
      busy_next[dec.rd] = 1'b1;
    end
    id_ex_o       = id_ex_ff;
    id_ex_o.valid = valid_ff;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_ff <= 1'b0;
      busy_ff  <= '0;
    end else begin
      busy_ff <= busy_next;
      if (flush_i) begin
        valid_ff <= 1'b0;
      end else if (issue) begin
        valid_ff <= 1'b1;
      end else if (id_ready_i) begin
        valid_ff <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wb_dec_i.we) begin
      regfile[wb_dec_i.rd] <= wb_dec_i.rd_data;
    end
    if (issue) begin
      id_ex_ff   <= dec;
      rs1_data_o <= rs1_val;
      rs2_data_o <= rs2_val;
    end
  end
endmodule

// File: execute.sv
// Execute stage, ALU and branch resolution
`timescale 1ns/1ps

module execute (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  nox_pkg::s_id_ex_t     id_ex_i,
  input  nox_pkg::rdata_t       rs1_data_i,
  input  nox_pkg::rdata_t       rs2_data_i,
  output logic                  id_ready_o,
  output nox_pkg::s_ex_mem_wb_t ex_mem_wb_o,
  output nox_pkg::s_lsu_op_t    lsu_o,
  input  logic                  lsu_bp_i,
  output logic                  fetch_req_o,
  output nox_pkg::pc_t          fetch_addr_o
);
  import nox_pkg::*;

  s_ex_mem_wb_t out_ff;
  s_lsu_op_t    lsu_ff;
  logic         out_valid_ff, lsu_valid_ff;
  logic         hold, accept, taken;
  rdata_t       op_b, alu_res;
  pc_t          pc_plus4, target;

  always_comb begin
    // Hold while a memory access is issued or outstanding
    hold       = lsu_bp_i || lsu_valid_ff;
    id_ready_o = !hold && !fetch_req_o;
    accept     = id_ex_i.valid && id_ready_o;
    op_b = id_ex_i.use_imm ? id_ex_i.imm : rs2_data_i;
    case (id_ex_i.alu_op)
      ALU_ADD: alu_res = rs1_data_i + op_b;
      ALU_SUB: alu_res = rs1_data_i - op_b;
      ALU_AND: alu_res = rs1_data_i & op_b;
      ALU_OR:  alu_res = rs1_data_i | op_b;
      ALU_XOR: alu_res = rs1_data_i ^ op_b;
      ALU_SLT: alu_res = rdata_t'($signed(rs1_data_i) < $signed(op_b));
      default: alu_res = '0;
    endcase
    pc_plus4 = id_ex_i.pc + 32'd4;
    target   = id_ex_i.pc + id_ex_i.imm;
    taken    = id_ex_i.is_jal ||
               (id_ex_i.is_branch && ((rs1_data_i == rs2_data_i) ^ id_ex_i.br_ne));
    ex_mem_wb_o       = out_ff;
    ex_mem_wb_o.valid = out_valid_ff;
    lsu_o             = lsu_ff;
    lsu_o.valid       = lsu_valid_ff;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_ff <= 1'b0;
      lsu_valid_ff <= 1'b0;
      fetch_req_o  <= 1'b0;
    end else begin
      if (!hold) begin
        out_valid_ff <= accept;
      end
      lsu_valid_ff <= accept && (id_ex_i.is_load || id_ex_i.is_store);
      // Redirect doubles as the decode flush
      fetch_req_o  <= accept && taken;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_ff.valid    <= 1'b1;
      out_ff.rd       <= id_ex_i.rd;
      out_ff.rd_we    <= id_ex_i.rd_we;
      out_ff.result   <= id_ex_i.is_jal ? pc_plus4 : alu_res;
      out_ff.is_load  <= id_ex_i.is_load;
      lsu_ff.valid    <= 1'b1;
      lsu_ff.is_store <= id_ex_i.is_store;
      lsu_ff.addr     <= alu_res;
      lsu_ff.wdata    <= rs2_data_i;
      fetch_addr_o    <= target;
    end
  end
endmodule

// File: fetch.sv
// Instruction fetch stage
`timescale 1ns/1ps

module fetch (
  input  logic                clk,
  input  logic                rst_n_i,
  output cb_pkg::s_cb_mosi_t  instr_cb_mosi_o,
  input  cb_pkg::s_cb_miso_t  instr_cb_miso_i,
  input  logic                fetch_start_i,
  input  nox_pkg::pc_t        fetch_start_addr_i,
  input  logic                fetch_req_i,
  input  nox_pkg::pc_t        fetch_addr_i,
  output logic                fetch_valid_o,
  input  logic                fetch_ready_i,
  output nox_pkg::instr_raw_t fetch_instr_o,
  output nox_pkg::pc_t        fetch_pc_o
);
  import nox_pkg::*;

  logic       running_ff, busy_ff, discard_ff, hold_valid_ff;
  pc_t        pc_ff, redir_pc_ff, hold_pc_ff;
  instr_raw_t hold_instr_ff;
  logic       req, ack, in_flight;

  always_comb begin
    // Keep requesting once issued, otherwise only when the hold slot frees up
    req       = running_ff && (busy_ff || !hold_valid_ff || fetch_ready_i);
    ack       = req && instr_cb_miso_i.ack;
    in_flight = req && !instr_cb_miso_i.ack;
    instr_cb_mosi_o       = '0;
    instr_cb_mosi_o.req   = req;
    instr_cb_mosi_o.addr  = pc_ff;
    fetch_valid_o = hold_valid_ff;
    fetch_instr_o = hold_instr_ff;
    fetch_pc_o    = hold_pc_ff;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      running_ff    <= 1'b0;
      busy_ff       <= 1'b0;
      discard_ff    <= 1'b0;
      hold_valid_ff <= 1'b0;
      pc_ff         <= '0;
    end else begin
      busy_ff <= in_flight;
      if (fetch_start_i) begin
        running_ff <= 1'b1;
      end
      if (fetch_req_i) begin
        hold_valid_ff <= 1'b0;
      end else if (ack && !discard_ff) begin
        hold_valid_ff <= 1'b1;
      end else if (hold_valid_ff && fetch_ready_i) begin
        hold_valid_ff <= 1'b0;
      end
      // Response of a killed request is dropped on arrival
      if (fetch_req_i) begin
        discard_ff <= in_flight;
      end else if (ack) begin
        discard_ff <= 1'b0;
      end
      if (fetch_start_i) begin
        pc_ff <= fetch_start_addr_i;
      end else if (fetch_req_i && !in_flight) begin
        pc_ff <= fetch_addr_i;
      end else if (ack) begin
        pc_ff <= discard_ff ? redir_pc_ff : pc_ff + 32'd4;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_req_i) begin
      redir_pc_ff <= fetch_addr_i;
    end
    if (ack && !discard_ff) begin
      hold_instr_ff <= instr_cb_miso_i.rdata;
      hold_pc_ff    <= pc_ff;
    end
  end
endmodule

// File: lsu.sv
// Load-store unit, data bus master
`timescale 1ns/1ps

module lsu (
  input  logic               clk,
  input  logic               rst_n_i,
  input  nox_pkg::s_lsu_op_t lsu_i,
  output logic               lsu_bp_o,
  output logic               lsu_done_o,
  output nox_pkg::rdata_t    lsu_rd_data_o,
  output cb_pkg::s_cb_mosi_t data_cb_mosi_o,
  input  cb_pkg::s_cb_miso_t data_cb_miso_i
);
  import nox_pkg::*;

  s_lsu_op_t op_ff, cur_op;
  logic      pending_ff, req, ack;

  always_comb begin
    // New op goes straight out, a pending one comes from the register
    cur_op = pending_ff ? op_ff : lsu_i;
    req    = pending_ff || lsu_i.valid;
    ack    = req && data_cb_miso_i.ack;
    data_cb_mosi_o.req   = req;
    data_cb_mosi_o.we    = cur_op.is_store;
    data_cb_mosi_o.addr  = cur_op.addr;
    data_cb_mosi_o.wdata = cur_op.wdata;
    lsu_bp_o      = pending_ff;
    lsu_done_o    = ack && !cur_op.is_store;
    lsu_rd_data_o = data_cb_miso_i.rdata;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_ff <= 1'b0;
    end else if (ack) begin
      pending_ff <= 1'b0;
    end else if (lsu_i.valid) begin
      pending_ff <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (lsu_i.valid && !pending_ff) begin
      op_ff <= lsu_i;
    end
  end
endmodule

// File: nox.sv
// RV32I five-stage core
`timescale 1ns/1ps

module nox (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               start_fetch_i,
  input  nox_pkg::pc_t       start_addr_i,
  output cb_pkg::s_cb_mosi_t instr_cb_mosi_o,
  input  cb_pkg::s_cb_miso_t instr_cb_miso_i,
  output cb_pkg::s_cb_mosi_t lsu_cb_mosi_o,
  input  cb_pkg::s_cb_miso_t lsu_cb_miso_i
);
  import nox_pkg::*;

  logic         fetch_valid, fetch_ready, fetch_req;
  instr_raw_t   fetch_instr;
  pc_t          fetch_pc, fetch_addr;
  s_wb_t        wb_dec;
  s_id_ex_t     id_ex;
  rdata_t       rs1_data, rs2_data, lsu_rd_data;
  logic         id_ready, lsu_bp, lsu_done;
  s_ex_mem_wb_t ex_mem_wb;
  s_lsu_op_t    lsu_op;

  fetch u_fetch (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .instr_cb_mosi_o    (instr_cb_mosi_o),
    .instr_cb_miso_i    (instr_cb_miso_i),
    .fetch_start_i      (start_fetch_i),
    .fetch_start_addr_i (start_addr_i),
    .fetch_req_i        (fetch_req),
    .fetch_addr_i       (fetch_addr),
    .fetch_valid_o      (fetch_valid),
    .fetch_ready_i      (fetch_ready),
    .fetch_instr_o      (fetch_instr),
    .fetch_pc_o         (fetch_pc)
  );

  decode u_decode (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .flush_i            (fetch_req),
    .fetch_valid_i      (fetch_valid),
    .fetch_ready_o      (fetch_ready),
    .fetch_instr_i      (fetch_instr),
    .fetch_pc_i         (fetch_pc),
    .wb_dec_i           (wb_dec),
    .id_ex_o            (id_ex),
    .rs1_data_o         (rs1_data),
    .rs2_data_o         (rs2_data),
    .id_ready_i         (id_ready)
  );

  execute u_execute (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .id_ex_i            (id_ex),
    .rs1_data_i         (rs1_data),
    .rs2_data_i         (rs2_data),
    .id_ready_o         (id_ready),
    .ex_mem_wb_o        (ex_mem_wb),
    .lsu_o              (lsu_op),
    .lsu_bp_i           (lsu_bp),
    .fetch_req_o        (fetch_req),
    .fetch_addr_o       (fetch_addr)
  );

  lsu u_lsu (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .lsu_i              (lsu_op),
    .lsu_bp_o           (lsu_bp),
    .lsu_done_o         (lsu_done),
    .lsu_rd_data_o      (lsu_rd_data),
    .data_cb_mosi_o     (lsu_cb_mosi_o),
    .data_cb_miso_i     (lsu_cb_miso_i)
  );

  wb u_wb (
    .ex_mem_wb_i        (ex_mem_wb),
    .lsu_done_i         (lsu_done),
    .lsu_rd_data_i      (lsu_rd_data),
    .wb_dec_o           (wb_dec)
  );
endmodule

// File: nox_pkg.sv
// Core types for the RV32I pipeline

package nox_pkg;
  localparam int XLEN    = 32;
  localparam int NR_REGS = 32;

  typedef logic [XLEN-1:0] pc_t;
  typedef logic [XLEN-1:0] rdata_t;
  typedef logic [31:0]     instr_raw_t;
  typedef logic [4:0]      raddr_t;

  // RV32I major opcodes in use
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_t;

  // Decode to execute
  typedef struct packed {
    logic    valid;
    pc_t     pc;
    raddr_t  rd;
    logic    rd_we;
    alu_op_t alu_op;
    rdata_t  imm;
    logic    use_imm;
    logic    is_load;
    logic    is_store;
    logic    is_branch;
    logic    is_jal;
    logic    br_ne;
  } s_id_ex_t;

  // Execute to write-back
  typedef struct packed {
    logic   valid;
    raddr_t rd;
    logic   rd_we;
    rdata_t result;
    logic   is_load;
  } s_ex_mem_wb_t;

  typedef struct packed {
    logic   valid;
    logic   is_store;
    rdata_t addr;
    rdata_t wdata;
  } s_lsu_op_t;

  // Register file write port, also clears the scoreboard
  typedef struct packed {
    logic   we;
    raddr_t rd;
    rdata_t rd_data;
  } s_wb_t;
endpackage

// File: tb_nox.sv
// Testbench for the nox core
`timescale 1ns/1ps

module tb_nox;
  import cb_pkg::*;

  localparam logic [31:0] SEED   = 32'h56fe_e9f5;
  localparam logic [31:0] MARKER = 32'h0000_3000;
  localparam logic [6:0]  OPR    = 7'b0110011;
  localparam logic [6:0]  OPI    = 7'b0010011;
  localparam int          NTESTS = 5;

  typedef struct {
    logic [31:0] start;
    logic [31:0] addr;
    logic [31:0] data;
    string       name;
  } test_t;

  logic        clk, rst_n, start_fetch;
  logic [31:0] start_addr, lfsr;
  s_cb_mosi_t  instr_mosi, lsu_mosi, m;
  s_cb_miso_t  instr_miso, lsu_miso;
  logic [31:0] imem [1024];
  logic [31:0] dmem [256];
  test_t       tests [NTESTS];
  logic        marker_seen;
  logic [31:0] marker_addr, marker_data;
  logic        busy [2], ack_q [2];
  logic [31:0] rdata_q [2], req_addr [2];
  string       bus_name [2];
  int          cnt [2];
  int          wp, errors, failed;

  nox i_dut (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .start_fetch_i   (start_fetch),
    .start_addr_i    (start_addr),
    .instr_cb_mosi_o (instr_mosi),
    .instr_cb_miso_i (instr_miso),
    .lsu_cb_mosi_o   (lsu_mosi),
    .lsu_cb_miso_i   (lsu_miso)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Galois LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb) begin
      s = s ^ 32'h8020_0003;
    end
    return s;
  endfunction

  task automatic draw_delay(output int d);
    logic b0, b1;
    b0 = lfsr[0];
    lfsr = lfsr_next(lfsr);
    b1 = lfsr[0];
    lfsr = lfsr_next(lfsr);
    d = {b1, b0};
  endtask

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPR};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic put(input logic [31:0] w);
    imem[wp] = w;
    wp++;
  endtask

  // Marker store at MARKER plus offset, then spin on a self jump
  task automatic finish_prog(input logic [4:0] rs, input logic [11:0] off);
    put(u_type(20'h00003, 5'd31));
    put(s_type(off, rs, 5'd31));
    put(j_type(21'd0, 5'd0));
  endtask

  task automatic load_programs();
    for (int i = 0; i < 1024; i++) begin
      imem[i] = {i[9:0], 15'h0, 7'b0001111};
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = {24'hd0d000, i[7:0]};
    end
    // ALU ops where each result feeds the next
    wp = 0;
    put(u_type(20'h12345, 5'd1));
    put(i_type(12'h123, 5'd0, 3'b000, 5'd2, OPI));
    put(i_type(-12'sd5, 5'd0, 3'b000, 5'd3, OPI));
    put(r_type(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
    put(r_type(7'h00, 3'b111, 5'd5, 5'd4, 5'd3));
    put(r_type(7'h00, 3'b110, 5'd6, 5'd5, 5'd2));
    put(r_type(7'h00, 3'b100, 5'd7, 5'd6, 5'd1));
    put(r_type(7'h00, 3'b010, 5'd8, 5'd3, 5'd2));
    put(r_type(7'h00, 3'b000, 5'd9, 5'd7, 5'd8));
    put(i_type(12'h0f0, 5'd9, 3'b100, 5'd9, OPI));
    put(i_type(-12'sd4, 5'd3, 3'b010, 5'd10, OPI));
    put(r_type(7'h00, 3'b000, 5'd9, 5'd9, 5'd10));
    put(i_type(12'h7ff, 5'd9, 3'b111, 5'd9, OPI));
    put(i_type(12'h100, 5'd9, 3'b110, 5'd9, OPI));
    finish_prog(5'd9, 12'h000);
    // Dependent chain on one register
    wp = 'h100 >> 2;
    put(i_type(12'd1, 5'd0, 3'b000, 5'd1, OPI));
    put(r_type(7'h00, 3'b000, 5'd1, 5'd1, 5'd1));
    put(r_type(7'h00, 3'b000, 5'd1, 5'd1, 5'd1));
    put(i_type(12'd3, 5'd1, 3'b000, 5'd1, OPI));
    put(r_type(7'h00, 3'b000, 5'd2, 5'd1, 5'd1));
    put(r_type(7'h20, 3'b000, 5'd2, 5'd2, 5'd1));
    put(i_type(12'd100, 5'd2, 3'b000, 5'd2, OPI));
    finish_prog(5'd2, 12'h004);
    // Store, load back, then use
    wp = 'h200 >> 2;
    put(u_type(20'h00002, 5'd1));
    put(i_type(12'h5a5, 5'd0, 3'b000, 5'd2, OPI));
    put(u_type(20'habcde, 5'd3));
    put(r_type(7'h00, 3'b110, 5'd3, 5'd3, 5'd2));
    put(s_type(12'd8, 5'd3, 5'd1));
    put(i_type(12'd8, 5'd1, 3'b010, 5'd4, 7'b0000011));
    put(i_type(12'd1, 5'd4, 3'b000, 5'd4, OPI));
    finish_prog(5'd4, 12'h008);
    // Branches and JAL where skipped adds would change x3
    wp = 'h300 >> 2;
    put(i_type(12'd5, 5'd0, 3'b000, 5'd1, OPI));
    put(i_type(12'd5, 5'd0, 3'b000, 5'd2, OPI));
    put(i_type(12'd0, 5'd0, 3'b000, 5'd3, OPI));
    put(b_type(13'd8, 5'd2, 5'd1, 3'b000));
    put(i_type(12'd1, 5'd3, 3'b000, 5'd3, OPI));
    put(b_type(13'd8, 5'd2, 5'd1, 3'b001));
    put(i_type(12'd16, 5'd3, 3'b000, 5'd3, OPI));
    put(j_type(21'd8, 5'd5));
    put(i_type(12'd256, 5'd3, 3'b000, 5'd3, OPI));
    put(r_type(7'h00, 3'b000, 5'd3, 5'd3, 5'd5));
    finish_prog(5'd3, 12'h00c);
    // Writes to x0 must not stick
    wp = 'h400 >> 2;
    put(i_type(12'h055, 5'd0, 3'b000, 5'd0, OPI));
    put(u_type(20'h12345, 5'd0));
    put(r_type(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
    finish_prog(5'd0, 12'h010);
  endtask

  // Both bus slaves with random ack delay
  initial begin
    bus_name[0] = "instr_cb_mosi_o";
    bus_name[1] = "lsu_cb_mosi_o";
    for (int b = 0; b < 2; b++) begin
      busy[b] = 1'b0;
      ack_q[b] = 1'b0;
      rdata_q[b] = '0;
      req_addr[b] = '0;
      cnt[b] = 0;
    end
    forever begin
      @(negedge clk);
      for (int b = 0; b < 2; b++) begin
        m = (b == 0) ? instr_mosi : lsu_mosi;
        if (!rst_n || ack_q[b]) begin
          ack_q[b] = 1'b0;
          busy[b] = 1'b0;
        end else begin
          // Request must stay up with the same address until its ack
          if (busy[b] && !m.req) begin
            $display("Bus %s dropped req before its ack", bus_name[b]);
            errors++;
          end else if (busy[b] && m.addr !== req_addr[b]) begin
            $display("Error: %s.addr got %h expected %h", bus_name[b], m.addr,
                     req_addr[b]);
            errors++;
          end
          if (b == 0 && m.req && m.we !== 1'b0) begin
            $display("Error: instr_cb_mosi_o.we got %h expected %h", m.we, 1'b0);
            errors++;
          end
          if (!busy[b] && m.req) begin
            draw_delay(cnt[b]);
            req_addr[b] = m.addr;
            busy[b] = 1'b1;
          end
          if (busy[b] && cnt[b] == 0) begin
            busy[b] = 1'b0;
            ack_q[b] = 1'b1;
            if (b == 0) begin
              rdata_q[b] = imem[m.addr[11:2]];
            end else if (m.we && m.addr >= MARKER) begin
              marker_seen = 1'b1;
              marker_addr = m.addr;
              marker_data = m.wdata;
            end else if (m.we) begin
              dmem[m.addr[9:2]] = m.wdata;
            end else begin
              rdata_q[b] = dmem[m.addr[9:2]];
            end
          end else if (busy[b]) begin
            cnt[b]--;
          end
        end
      end
      @(posedge clk);
      #10;
      instr_miso.ack   = ack_q[0];
      instr_miso.rdata = rdata_q[0];
      lsu_miso.ack     = ack_q[1];
      lsu_miso.rdata   = rdata_q[1];
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    #10;
    rst_n = 1'b0;
    start_fetch = 1'b0;
    repeat (4) @(posedge clk);
    #10;
    rst_n = 1'b1;
  endtask

  initial begin
    int cycles;
    rst_n = 1'b0;
    start_fetch = 1'b0;
    start_addr = '0;
    instr_miso = '0;
    lsu_miso = '0;
    lfsr = SEED;
    marker_seen = 1'b0;
    failed = 0;
    load_programs();
    tests[0] = '{32'h0000_0000, MARKER,          32'h0000_070d, "alu ops"};
    tests[1] = '{32'h0000_0100, MARKER + 32'd4,  32'h0000_006b, "dependent chain"};
    tests[2] = '{32'h0000_0200, MARKER + 32'd8,  32'habcd_e5a6, "store and load"};
    tests[3] = '{32'h0000_0300, MARKER + 32'd12, 32'h0000_0330, "branch and jal"};
    tests[4] = '{32'h0000_0400, MARKER + 32'd16, 32'h0000_0000, "x0 writes"};
    for (int t = 0; t < NTESTS; t++) begin
      errors = 0;
      apply_reset();
      marker_seen = 1'b0;
      @(posedge clk);
      #10;
      start_fetch = 1'b1;
      start_addr = tests[t].start;
      @(posedge clk);
      #10;
      start_fetch = 1'b0;
      cycles = 0;
      while (!marker_seen && cycles < 2000) begin
        @(posedge clk);
        cycles++;
      end
      if (!marker_seen) begin
        $display("Test %s timed out waiting for the marker store", tests[t].name);
        errors++;
      end else begin
        if (marker_addr !== tests[t].addr) begin
          $display("Error: lsu_cb_mosi_o.addr got %h expected %h", marker_addr, tests[t].addr);
          errors++;
        end
        if (marker_data !== tests[t].data) begin
          $display("Error: lsu_cb_mosi_o.wdata got %h expected %h", marker_data,
                   tests[t].data);
          errors++;
        end
      end
      if (errors == 0) begin
        $display("Test %s ok", tests[t].name);
      end else begin
        $display("Test %s FAILED", tests[t].name);
        failed++;
      end
    end
    $display("Tests run %0d, failed %0d", NTESTS, failed);
    if (failed == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end
endmodule

// File: verilog.f
nox_pkg.sv
cb_pkg.sv
fetch.sv
decode.sv
execute.sv
lsu.sv
wb.sv
nox.sv
tb_nox.sv

// File: wb.sv
// Write-back select
`timescale 1ns/1ps

module wb (
  input  nox_pkg::s_ex_mem_wb_t ex_mem_wb_i,
  input  logic                  lsu_done_i,
  input  nox_pkg::rdata_t       lsu_rd_data_i,
  output nox_pkg::s_wb_t        wb_dec_o
);
  logic wr_en;

  always_comb begin
    wr_en = 1'b0;
    if (ex_mem_wb_i.valid && ex_mem_wb_i.rd_we) begin
      // Loads wait for the data bus ack
      wr_en = ex_mem_wb_i.is_load ? lsu_done_i : 1'b1;
    end
    wb_dec_o.we      = wr_en && (ex_mem_wb_i.rd != '0);
    wb_dec_o.rd      = ex_mem_wb_i.rd;
    wb_dec_o.rd_data = ex_mem_wb_i.is_load ? lsu_rd_data_i : ex_mem_wb_i.result;
  end
endmodule
